// ==== elink_settings.svh ====
`ifndef ELINK_SETTINGS_SVH
`define ELINK_SETTINGS_SVH

// Number of words in the transmit FIFO, must be a power of two
`define ELINK_FIFO_DEPTH 32

// Fill count at which the programmable-full flag rises
`define ELINK_PFULL_LEVEL 24

`endif

// ==== enc_8b10b_pkg.sv ====
`default_nettype none

package enc_8b10b_pkg;

  // Running disparity of the encoded stream
  typedef enum logic
  {
    RD_NEG = 1'b0,
    RD_POS = 1'b1
  } disp_t;

  // Sub-blocks as the encoder builds them, bit a is the MSB
  typedef struct packed
  {
    logic [5:0] abcdei;
    logic [3:0] fghj;
  } code_sub_t;

  // One code group, seen as a raw word or as its two sub-blocks
  typedef union packed
  {
    logic [9:0] raw;
    code_sub_t  sub;
  } code_group_u;

  // Control characters, all of them K28.y
  localparam logic [7:0] K28_5 = 8'hBC;
  localparam logic [7:0] K28_1 = 8'h3C;
  localparam logic [7:0] K28_6 = 8'hDC;

  // Idle comma at negative disparity, the first group after reset
  localparam logic [9:0] K28_5_RDN = 10'b001111_1010;

endpackage

`default_nettype wire

// ==== elink_pkg.sv ====
`default_nettype none

package elink_pkg;

  // Delimiter carried in the upper bits of each FIFO word
  typedef enum logic [1:0]
  {
    DELIM_DATA  = 2'd0,
    DELIM_EOP   = 2'd1,
    DELIM_SOP   = 2'd2,
    // Explicit idle, sent as a comma
    DELIM_COMMA = 2'd3
  } delim_t;

  // Word as written by the user into the transmit FIFO
  typedef struct packed
  {
    delim_t     delim;
    logic [7:0] data;
  } fifo_word_t;

endpackage

`default_nettype wire

// ==== efifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "elink_settings.svh"

module efifo (
  input  wire                   clk_160,
  input  wire                   reset,
  input  wire                   fifo_flush,
  input  wire                   wr,
  input  wire elink_pkg::fifo_word_t din,
  input  wire                   pop,
  output elink_pkg::fifo_word_t head_word,
  output logic                  head_valid,
  output logic                  pfull
);

  localparam int DEPTH = `ELINK_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = AW + 1;

  elink_pkg::fifo_word_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          full;
  logic          do_wr;
  logic          do_pop;

  assign full   = (count == CW'(DEPTH));
  // Writes into a full FIFO are dropped
  assign do_wr  = wr && !full;
  assign do_pop = pop && head_valid;

  always_ff @(posedge clk_160)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk_160)
  begin
    if (reset || fifo_flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Pointers wrap on their own since depth is a power of two
      if (do_wr)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_pop})
        2'b10:
        begin
          count <= count + 1'b1;
        end
        2'b01:
        begin
          count <= count - 1'b1;
        end
        default:
        begin
          count <= count;
        end
      endcase
    end
  end

  // Fall-through head, no read latency
  assign head_word  = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign pfull      = (count >= CW'(`ELINK_PFULL_LEVEL));

  // The encoder only takes a word that is actually there
  property pop_needs_head;
    @(posedge clk_160) disable iff (reset)
      pop |-> head_valid;
  endproperty

  assert property (pop_needs_head)
    else $error("efifo: pop while FIFO empty");

endmodule

`default_nettype wire

// ==== enc_8b10b.sv ====
`timescale 1ns/1ps
`default_nettype none

module enc_8b10b (
  input  wire                         clk_160,
  input  wire                         reset,
  input  wire elink_pkg::fifo_word_t  head_word,
  input  wire                         head_valid,
  input  wire                         group_take,
  output logic                        head_pop,
  output enc_8b10b_pkg::code_group_u  code_out
);

  enc_8b10b_pkg::disp_t       rd;
  enc_8b10b_pkg::disp_t       rd6;
  enc_8b10b_pkg::disp_t       rd_nxt;
  enc_8b10b_pkg::code_group_u nxt;

  logic [7:0] char_val;
  logic       char_k;
  logic [5:0] base6;
  logic [3:0] base4;
  logic       use_a7;

  function automatic logic [2:0] count_ones(input logic [5:0] v);
    logic [2:0] n;
    n = 3'd0;
    for (int i = 0; i < 6; i++)
    begin
      n = n + {2'b00, v[i]};
    end
    return n;
  endfunction

  // 5b/6b table, values for negative running disparity
  function automatic logic [5:0] code_6b_neg(input logic [4:0] x);
    logic [5:0] c;
    case (x)
      5'd0:  c = 6'b100111;
      5'd1:  c = 6'b011101;
      5'd2:  c = 6'b101101;
      5'd3:  c = 6'b110001;
      5'd4:  c = 6'b110101;
      5'd5:  c = 6'b101001;
      5'd6:  c = 6'b011001;
      5'd7:  c = 6'b111000;
      5'd8:  c = 6'b111001;
      5'd9:  c = 6'b100101;
      5'd10: c = 6'b010101;
      5'd11: c = 6'b110100;
      5'd12: c = 6'b001101;
      5'd13: c = 6'b101100;
      5'd14: c = 6'b011100;
      5'd15: c = 6'b010111;
      5'd16: c = 6'b011011;
      5'd17: c = 6'b100011;
      5'd18: c = 6'b010011;
      5'd19: c = 6'b110010;
      5'd20: c = 6'b001011;
      5'd21: c = 6'b101010;
      5'd22: c = 6'b011010;
      5'd23: c = 6'b111010;
      5'd24: c = 6'b110011;
      5'd25: c = 6'b100110;
      5'd26: c = 6'b010110;
      5'd27: c = 6'b110110;
      5'd28: c = 6'b001110;
      5'd29: c = 6'b101110;
      5'd30: c = 6'b011110;
      default: c = 6'b101011;
    endcase
    return c;
  endfunction

  // 3b/4b table for D characters at negative disparity
  function automatic logic [3:0] code_4b_neg(input logic [2:0] y, input logic alt7);
    logic [3:0] c;
    case (y)
      3'd0: c = 4'b1011;
      3'd1: c = 4'b1001;
      3'd2: c = 4'b0101;
      3'd3: c = 4'b1100;
      3'd4: c = 4'b1101;
      3'd5: c = 4'b1010;
      3'd6: c = 4'b0110;
      default: c = alt7 ? 4'b0111 : 4'b1110;
    endcase
    return c;
  endfunction

  // Pick the character to send, idle comma when nothing is queued
  always_comb
  begin
    char_val = enc_8b10b_pkg::K28_5;
    char_k   = 1'b1;
    if (head_valid)
    begin
      case (head_word.delim)
        elink_pkg::DELIM_DATA:
        begin
          char_val = head_word.data;
          char_k   = 1'b0;
        end
        elink_pkg::DELIM_SOP:
        begin
          char_val = enc_8b10b_pkg::K28_1;
        end
        elink_pkg::DELIM_EOP:
        begin
          char_val = enc_8b10b_pkg::K28_6;
        end
        default:
        begin
          char_val = enc_8b10b_pkg::K28_5;
        end
      endcase
    end
  end

  always_comb
  begin
    // Only K28 control characters are used on this link
    base6 = char_k ? 6'b001111 : code_6b_neg(char_val[4:0]);
    // Unbalanced blocks and D.07 flip at positive disparity
    if (rd == enc_8b10b_pkg::RD_POS && (count_ones(base6) != 3'd3 || base6 == 6'b111000))
    begin
      nxt.sub.abcdei = ~base6;
    end
    else
    begin
      nxt.sub.abcdei = base6;
    end
    rd6 = (count_ones(nxt.sub.abcdei) != 3'd3) ? enc_8b10b_pkg::disp_t'(~rd) : rd;

    // Alternate x.7 avoids a run of five equal bits
    use_a7 = (char_val[7:5] == 3'd7) &&
             (char_k ||
              (rd6 == enc_8b10b_pkg::RD_NEG && char_val[4:0] inside {5'd17, 5'd18, 5'd20}) ||
              (rd6 == enc_8b10b_pkg::RD_POS && char_val[4:0] inside {5'd11, 5'd13, 5'd14}));
    base4 = code_4b_neg(char_val[7:5], use_a7);
    // K.x.1, K.x.2, K.x.5, K.x.6 invert the balanced D pattern
    if (char_k && char_val[7:5] inside {3'd1, 3'd2, 3'd5, 3'd6})
    begin
      base4 = ~base4;
    end
    if (rd6 == enc_8b10b_pkg::RD_POS &&
        (char_k || count_ones({2'b00, base4}) != 3'd2 || base4 == 4'b1100))
    begin
      nxt.sub.fghj = ~base4;
    end
    else
    begin
      nxt.sub.fghj = base4;
    end
    rd_nxt = (count_ones({2'b00, nxt.sub.fghj}) != 3'd2) ? enc_8b10b_pkg::disp_t'(~rd6) : rd6;
  end

  always_ff @(posedge clk_160)
  begin
    if (reset)
    begin
      code_out.raw <= enc_8b10b_pkg::K28_5_RDN;
      // Disparity after the reset comma
      rd <= enc_8b10b_pkg::RD_POS;
    end
    else if (group_take)
    begin
      code_out <= nxt;
      rd       <= rd_nxt;
    end
  end

  assign head_pop = group_take && head_valid;

  // Every new group is balanced or off by two
  property group_balance;
    @(posedge clk_160) disable iff (reset)
      group_take |=> ($countones(code_out.raw) inside {[4:6]});
  endproperty

  assert property (group_balance)
    else $error("enc_8b10b: code group with bad disparity");

endmodule

`default_nettype wire

// ==== elink_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module elink_serializer (
  input  wire                              clk_160,
  input  wire                              reset,
  input  wire enc_8b10b_pkg::code_group_u  code_in,
  input  wire                              bit_reverse,
  input  wire                              swap_output,
  output logic                             group_take,
  output logic [1:0]                       elink
);

  logic [2:0] phase;
  logic [9:0] load_bits;
  logic [9:0] shift_reg;

  // Reversed order sends bit j first
  always_comb
  begin
    for (int i = 0; i < 10; i++)
    begin
      load_bits[i] = bit_reverse ? code_in.raw[9-i] : code_in.raw[i];
    end
  end

  // Modulo-5 phase, one group per five cycles
  always_ff @(posedge clk_160)
  begin
    if (reset)
    begin
      phase <= 3'd0;
    end
    else if (phase == 3'd4)
    begin
      phase <= 3'd0;
    end
    else
    begin
      phase <= phase + 3'd1;
    end
  end

  assign group_take = (phase == 3'd0);

  always_ff @(posedge clk_160)
  begin
    if (reset)
    begin
      shift_reg <= '0;
    end
    else if (group_take)
    begin
      shift_reg <= load_bits;
    end
    else
    begin
      shift_reg <= {shift_reg[7:0], 2'b00};
    end
  end

  // Earlier bit on lane 1 unless swapped
  assign elink = swap_output ? {shift_reg[8], shift_reg[9]} : shift_reg[9:8];

  property take_period;
    @(posedge clk_160) disable iff (reset)
      group_take |=> !group_take [*4] ##1 group_take;
  endproperty

  assert property (take_period)
    else $error("elink_serializer: group_take out of cadence");

endmodule

`default_nettype wire

// ==== fifo_to_elink.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_to_elink (
  input  wire                         clk_160,
  input  wire                         reset,
  input  wire                         fifo_flush,
  input  wire                         efifo_wr,
  input  wire elink_pkg::fifo_word_t  efifo_din,
  output logic                        efifo_pfull,
  input  wire                         bit_reverse,
  input  wire                         swap_output,
  output logic [1:0]                  elink
);

  elink_pkg::fifo_word_t      head_word;
  logic                       head_valid;
  logic                       head_pop;
  logic                       group_take;
  enc_8b10b_pkg::code_group_u code_group;

  efifo i_efifo (
    .clk_160    (clk_160),
    .reset      (reset),
    .fifo_flush (fifo_flush),
    .wr         (efifo_wr),
    .din        (efifo_din),
    .pop        (head_pop),
    .head_word  (head_word),
    .head_valid (head_valid),
    .pfull      (efifo_pfull)
  );

  // Encoder refills its group on every serializer load
  enc_8b10b i_enc_8b10b (
    .clk_160    (clk_160),
    .reset      (reset),
    .head_word  (head_word),
    .head_valid (head_valid),
    .group_take (group_take),
    .head_pop   (head_pop),
    .code_out   (code_group)
  );

  elink_serializer i_elink_serializer (
    .clk_160     (clk_160),
    .reset       (reset),
    .code_in     (code_group),
    .bit_reverse (bit_reverse),
    .swap_output (swap_output),
    .group_take  (group_take),
    .elink       (elink)
  );

endmodule

`default_nettype wire

// ==== tb_enc_ref.svh ====
`ifndef TB_ENC_REF_SVH
`define TB_ENC_REF_SVH

// 5b/6b codes abcdei at negative disparity, D.00 in the top slice
localparam logic [191:0] REF_6B = {
  6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
  6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
  6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
  6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b codes fghj at negative disparity, primary x.7 last
localparam logic [31:0] REF_4B = {
  4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};

function automatic int ones_in(input logic [9:0] v);
  int n;
  n = 0;
  for (int i = 0; i < 10; i++)
    n = n + v[i];
  return n;
endfunction

function automatic enc_8b10b_pkg::code_group_u ref_encode(
  input elink_pkg::fifo_word_t w,
  input enc_8b10b_pkg::disp_t  rd
);
  enc_8b10b_pkg::code_group_u g;
  logic [4:0] x;
  logic [2:0] y;
  logic       pos6;
  x = w.data[4:0];
  y = w.data[7:5];
  case (w.delim)
    elink_pkg::DELIM_SOP:
      g.raw = 10'b0011111001;
    elink_pkg::DELIM_EOP:
      g.raw = 10'b0011110110;
    elink_pkg::DELIM_COMMA:
      g.raw = 10'b0011111010;
    default:
    begin
      g.sub.abcdei = REF_6B[(31 - x) * 6 +: 6];
      if (rd == enc_8b10b_pkg::RD_POS && (ones_in(g.sub.abcdei) != 3 || x == 5'd7))
        g.sub.abcdei = ~g.sub.abcdei;
      // Unbalanced sub-block sets the disparity to its own sign
      pos6 = (ones_in(g.sub.abcdei) == 3) ? (rd == enc_8b10b_pkg::RD_POS)
                                           : (ones_in(g.sub.abcdei) > 3);
      g.sub.fghj = REF_4B[(7 - y) * 4 +: 4];
      if (y == 3'd7 && (pos6 ? (x == 11 || x == 13 || x == 14) : (x == 17 || x == 18 || x == 20)))
        g.sub.fghj = 4'b0111;
      if (pos6 && (ones_in(g.sub.fghj) != 2 || y == 3'd3))
        g.sub.fghj = ~g.sub.fghj;
      return g;
    end
  endcase
  // K28 groups at positive disparity are the complement
  if (rd == enc_8b10b_pkg::RD_POS)
    g.raw = ~g.raw;
  return g;
endfunction

// Anything but five ones flips the running disparity
function automatic enc_8b10b_pkg::disp_t ref_next_rd(
  input enc_8b10b_pkg::code_group_u g,
  input enc_8b10b_pkg::disp_t       rd
);
  if (ones_in(g.raw) == 5)
    return rd;
  return (rd == enc_8b10b_pkg::RD_NEG) ? enc_8b10b_pkg::RD_POS : enc_8b10b_pkg::RD_NEG;
endfunction

`endif

// ==== tb_fifo_to_elink.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "elink_settings.svh"

module tb_fifo_to_elink;

  logic                  clk_160;
  logic                  reset;
  logic                  fifo_flush;
  logic                  efifo_wr;
  elink_pkg::fifo_word_t efifo_din;
  logic                  efifo_pfull;
  logic                  bit_reverse;
  logic                  swap_output;
  logic [1:0]            elink;

  bit                    link_bits[$];
  elink_pkg::fifo_word_t exp_q[$];
  enc_8b10b_pkg::disp_t  chk_rd;
  bit                    synced;
  int                    seen;
  int                    idles;
  int                    cyc;
  integer                seed;

  // Bytes whose codes depend on the running disparity, first byte on top
  localparam logic [47:0] DISP_BYTES = {8'h07, 8'hF1, 8'hEB, 8'h7C, 8'hF4, 8'hE7};

  `include "tb_enc_ref.svh"

  fifo_to_elink i_fifo_to_elink (
    .clk_160     (clk_160),
    .reset       (reset),
    .fifo_flush  (fifo_flush),
    .efifo_wr    (efifo_wr),
    .efifo_din   (efifo_din),
    .efifo_pfull (efifo_pfull),
    .bit_reverse (bit_reverse),
    .swap_output (swap_output),
    .elink       (elink)
  );

  always #4 clk_160 = ~clk_160;

  // Cycles since reset release, a group starts when this ends in 1 mod 5
  always @(posedge clk_160)
    cyc <= reset ? 0 : cyc + 1;

  // Earlier bit of each pair first
  always @(negedge clk_160)
  begin
    if (!reset)
    begin
      link_bits.push_back(swap_output ? elink[0] : elink[1]);
      link_bits.push_back(swap_output ? elink[1] : elink[0]);
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_group(input string name, input enc_8b10b_pkg::code_group_u got,
                             input enc_8b10b_pkg::code_group_u exp);
    if (got !== exp)
      fail_now($sformatf("MISMATCH %s got 0x%03h expected 0x%03h", name, got.raw, exp.raw));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_now($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [7:0] rand_byte();
    integer r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // Align on the first comma, then check one group per ten bits
  task automatic drain_link();
    enc_8b10b_pkg::code_group_u g;
    enc_8b10b_pkg::code_group_u idle;
    while (link_bits.size() >= 10)
    begin
      for (int i = 0; i < 10; i++)
        g.raw[bit_reverse ? i : 9 - i] = link_bits[i];
      idle = ref_encode({elink_pkg::DELIM_COMMA, 8'h00}, chk_rd);
      if (!synced && g != idle)
        void'(link_bits.pop_front());
      else
      begin
        synced = 1'b1;
        if (g == idle)
          idles++;
        else if (exp_q.size() == 0)
          fail_now($sformatf("Unexpected group 0x%03h on the link with no word pending", g.raw));
        else
        begin
          check_group("elink", g, ref_encode(exp_q[0], chk_rd));
          void'(exp_q.pop_front());
          seen++;
        end
        chk_rd = ref_next_rd(g, chk_rd);
        repeat (10) void'(link_bits.pop_front());
      end
    end
  endtask

  task automatic tick();
    @(posedge clk_160);
    #1;
    drain_link();
  endtask

  task automatic do_reset();
    reset = 1'b1;
    repeat (3) tick();
    link_bits.delete();
    exp_q.delete();
    synced = 1'b0;
    chk_rd = enc_8b10b_pkg::RD_NEG;
    seen   = 0;
    idles  = 0;
    reset  = 1'b0;
  endtask

  task automatic write_word(input elink_pkg::delim_t d, input logic [7:0] data);
    efifo_wr        = 1'b1;
    efifo_din.delim = d;
    efifo_din.data  = data;
    exp_q.push_back(efifo_din);
    tick();
    efifo_wr = 1'b0;
  endtask

  task automatic send_frame(input int n, input bit random_data);
    write_word(elink_pkg::DELIM_SOP, 8'h00);
    for (int i = 0; i < n; i++)
      write_word(elink_pkg::DELIM_DATA, random_data ? rand_byte() : 8'(8'h5A + 29 * i));
    write_word(elink_pkg::DELIM_EOP, 8'h00);
  endtask

  task automatic wait_delivered(input int limit);
    int n;
    n = 0;
    while (exp_q.size() > 0)
    begin
      if (n == limit)
        fail_now($sformatf("Timeout: expected word %0d (0x%03h) never arrived on the link",
                           seen, exp_q[0]));
      tick();
      n++;
    end
  endtask

  // Keeps a whole frame from overrunning the FIFO
  task automatic wait_room(input int limit);
    int n;
    n = 0;
    while (efifo_pfull)
    begin
      if (n == limit)
        fail_now("Timeout: efifo_pfull never fell while the link drained the FIFO");
      tick();
      n++;
    end
  endtask

  task automatic test_pfull();
    int  model;
    int  writes;
    bit  had_word;
    do_reset();
    model  = 0;
    writes = 0;
    // One write per cycle while the link drains one word per five
    while (model < `ELINK_PFULL_LEVEL + 2)
    begin
      if (writes == 64)
        fail_now("Timeout: FIFO fill never reached the programmable-full level");
      had_word = (model > 0);
      write_word(elink_pkg::DELIM_DATA, rand_byte());
      writes++;
      model++;
      if (cyc % 5 == 1 && had_word)
        model--;
      check_flag("efifo_pfull", efifo_pfull, model >= `ELINK_PFULL_LEVEL);
      // At most one word in the encoder and one in the shift register
      if (writes - seen < model || writes - seen > model + 2)
        fail_now("Words seen on the link do not agree with the FIFO fill");
    end
    wait_delivered(5 * exp_q.size() + 30);
    check_flag("efifo_pfull", efifo_pfull, 1'b0);
  endtask

  task automatic test_flush();
    int n;
    n = 0;
    while (cyc % 5 != 1)
    begin
      if (n == 10)
        fail_now("Timeout: the link never reached the start of a group");
      tick();
      n++;
    end
    // Three words land before the next take and are flushed just ahead of it
    for (int i = 0; i < 3; i++)
    begin
      efifo_wr        = 1'b1;
      efifo_din.delim = elink_pkg::DELIM_DATA;
      efifo_din.data  = 8'(8'hA0 + i);
      tick();
    end
    efifo_wr   = 1'b0;
    fifo_flush = 1'b1;
    tick();
    fifo_flush = 1'b0;
    send_frame(3, 1'b1);
    wait_delivered(5 * exp_q.size() + 30);
  endtask

  initial
  begin
    seed        = 32'h519f;
    clk_160     = 1'b0;
    reset       = 1'b1;
    fifo_flush  = 1'b0;
    efifo_wr    = 1'b0;
    efifo_din   = '0;
    bit_reverse = 1'b0;
    swap_output = 1'b0;

    // Idle commas only, disparity alternating from negative
    do_reset();
    repeat (60) tick();
    if (!synced || idles < 8)
      fail_now("No idle comma stream found on the link after reset");

    send_frame(4, 1'b0);
    wait_delivered(60);

    // Bytes whose codes depend on disparity, then random frames
    for (int i = 0; i < 6; i++)
      write_word(elink_pkg::DELIM_DATA, DISP_BYTES[47 - 8 * i -: 8]);
    for (int f = 0; f < 4; f++)
    begin
      wait_room(60);
      send_frame(1 + rand_byte() % 8, 1'b1);
    end
    wait_delivered(5 * exp_q.size() + 30);

    test_pfull();
    test_flush();

    for (int mode = 1; mode < 4; mode++)
    begin
      bit_reverse = mode[0];
      swap_output = mode[1];
      do_reset();
      send_frame(4, 1'b1);
      wait_delivered(80);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
enc_8b10b_pkg.sv
elink_pkg.sv
efifo.sv
enc_8b10b.sv
elink_serializer.sv
fifo_to_elink.sv
tb_fifo_to_elink.sv

// ==== Bender.yml ====
package:
  name: fifo_to_elink

export_include_dirs:
  - .

sources:
  - files:
      - enc_8b10b_pkg.sv
      - elink_pkg.sv
      - efifo.sv
      - enc_8b10b.sv
      - elink_serializer.sv
      - fifo_to_elink.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fifo_to_elink.sv
